/* common/osd_cfg.svh */
// osd geometry, buffer size and command byte layout constants
`ifndef OSD_CFG_SVH
`define OSD_CFG_SVH

// --------------------------------------------------
// beam counter widths
// --------------------------------------------------
`define OSD_HBEAM_W 11
`define OSD_VBEAM_W 9

// --------------------------------------------------
// display buffer, 8 rows of 256 bytes
// --------------------------------------------------
`define OSD_BUF_DEPTH 2048
`define OSD_BUF_AW 11

// --------------------------------------------------
// overlay window on the raster
// --------------------------------------------------
// 512 clocks wide, two clocks per buffer byte
`define OSD_HWIN_START 896
`define OSD_HWIN_END 1407
// 64 lines, 8 per text row
`define OSD_VWIN_START 128
`define OSD_VWIN_END 191

// data byte index carrying the row in a buffer write
`define OSD_LINE_BYTE 3

`endif

/* common/osd_cmd_pkg.sv */
// host command side types of the osd controller
package osd_cmd_pkg;

`include "osd_cfg.svh"

  // one byte from the host link
  typedef logic [7:0] osd_byte_t;

  // command code, bits 7:2 of a command byte
  typedef enum logic [5:0] {
    NOP        = 6'b0_000_00,
    RESET_CTRL = 6'b0_000_10,
    OSD_CTRL   = 6'b0_010_10,
    CHIP_CFG   = 6'b0_000_01,
    VIDEO_CFG  = 6'b0_011_01,
    OSD_BUFFER = 6'b0_000_11
  } osd_cmd_e;

  // data byte index within a command
  typedef logic [2:0] osd_dat_cnt_t;

  // counter stops one past the row byte
  parameter osd_dat_cnt_t DAT_CNT_MAX = osd_dat_cnt_t'(`OSD_LINE_BYTE + 1);

  // per command selects, each already qualified by a data strobe
  typedef struct packed {
    logic reset_ctrl;
    logic osd_ctrl;
    logic chip_cfg;
    logic video_cfg;
    logic osd_buffer;
    logic dat;
  } osd_sel_t;

  // reset control, msb first as sent
  typedef struct packed {
    logic cpuhlt;
    logic cpurst;
    logic usrrst;
  } osd_reset_ctrl_t;

  // video config byte DDHHLLSS
  typedef struct packed {
    logic [1:0] dither;
    logic [1:0] hires;
    logic [1:0] lores;
    logic [1:0] scanline;
  } osd_video_cfg_t;

  // chipset features GEANT
  typedef logic [4:0] chipset_cfg_t;

endpackage

/* common/osd_video_pkg.sv */
// raster side types of the osd controller
package osd_video_pkg;

`include "osd_cfg.svh"

  // --------------------------------------------------
  // beam positions
  // --------------------------------------------------
  // clocks since start of line
  typedef logic [`OSD_HBEAM_W-1:0] hbeam_t;
  // lines since start of frame
  typedef logic [`OSD_VBEAM_W-1:0] vbeam_t;

  // --------------------------------------------------
  // display buffer
  // --------------------------------------------------
  // row in bits 10:8, column byte below
  typedef logic [`OSD_BUF_AW-1:0] buf_addr_t;

  // one buffer write request
  typedef struct packed {
    logic                  we;
    osd_cmd_pkg::osd_byte_t data;
  } osd_wr_t;

endpackage

/* rtl/osd_cmd_decoder.sv */
// command byte latch, data byte counter and register select decode
`timescale 1ns/1ps

module osd_cmd_decoder (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      spi_rx,
  input  logic                      spi_cmd,
  input  osd_cmd_pkg::osd_byte_t    spi_dat,
  output osd_cmd_pkg::osd_sel_t     sel,
  output osd_cmd_pkg::osd_dat_cnt_t dat_cnt
);

  osd_cmd_pkg::osd_cmd_e cmd_q;
  logic                  cmd_strobe;
  logic                  dat_strobe;

  assign cmd_strobe = spi_rx & spi_cmd;
  assign dat_strobe = spi_rx & ~spi_cmd;

  // --------------------------------------------------
  // command latch and byte counter
  // --------------------------------------------------
  // code sits in the upper six bits
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_q <= osd_cmd_pkg::NOP;
    end else if (cmd_strobe) begin
      cmd_q <= osd_cmd_pkg::osd_cmd_e'(spi_dat[7:2]);
    end
  end

  // counts data bytes, stops at the first byte past the row
  always_ff @(posedge clk) begin
    if (reset) begin
      dat_cnt <= '0;
    end else if (cmd_strobe) begin
      dat_cnt <= '0;
    end else if (dat_strobe && (dat_cnt != osd_cmd_pkg::DAT_CNT_MAX)) begin
      dat_cnt <= dat_cnt + osd_cmd_pkg::osd_dat_cnt_t'(1);
    end
  end

  // --------------------------------------------------
  // select decode
  // --------------------------------------------------
  always_comb begin
    sel = '0;
    sel.dat = dat_strobe;
    case (cmd_q)
      osd_cmd_pkg::RESET_CTRL: sel.reset_ctrl = dat_strobe;
      osd_cmd_pkg::OSD_CTRL:   sel.osd_ctrl   = dat_strobe;
      osd_cmd_pkg::CHIP_CFG:   sel.chip_cfg   = dat_strobe;
      osd_cmd_pkg::VIDEO_CFG:  sel.video_cfg  = dat_strobe;
      osd_cmd_pkg::OSD_BUFFER: sel.osd_buffer = dat_strobe;
      // nop and dropped commands select nothing
      default: ;
    endcase
  end

  // a data byte never reaches two targets
  a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0({sel.reset_ctrl, sel.osd_ctrl, sel.chip_cfg, sel.video_cfg, sel.osd_buffer}))
    else $error("osd decoder drove more than one select");

endmodule

/* rtl/osd_config_regs.sv */
// control and configuration registers loaded from the first data byte
`timescale 1ns/1ps

module osd_config_regs (
  input  logic                         clk,
  input  logic                         reset,
  input  osd_cmd_pkg::osd_sel_t        sel,
  input  osd_cmd_pkg::osd_dat_cnt_t    dat_cnt,
  input  osd_cmd_pkg::osd_byte_t       spi_dat,
  output osd_cmd_pkg::osd_reset_ctrl_t reset_ctrl,
  output logic                         osd_enable,
  output logic                         key_disable,
  output osd_cmd_pkg::osd_video_cfg_t  video_cfg,
  output osd_cmd_pkg::chipset_cfg_t    chipset_cfg
);

  logic                      first_byte;
  // staged chipset value, powers up clear
  osd_cmd_pkg::chipset_cfg_t chip_shadow = '0;

  // only byte 0 of a command writes
  assign first_byte = (dat_cnt == '0);

  // --------------------------------------------------
  // reset, osd and video registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      // cpu held halted and in reset until the host lets go
      reset_ctrl  <= '{cpuhlt: 1'b1, cpurst: 1'b1, usrrst: 1'b0};
      osd_enable  <= 1'b0;
      key_disable <= 1'b0;
      video_cfg   <= '0;
    end else if (first_byte) begin
      if (sel.reset_ctrl) begin
        reset_ctrl <= osd_cmd_pkg::osd_reset_ctrl_t'(spi_dat[2:0]);
      end
      // byte layout KE
      if (sel.osd_ctrl) begin
        key_disable <= spi_dat[1];
        osd_enable  <= spi_dat[0];
      end
      if (sel.video_cfg) begin
        video_cfg <= osd_cmd_pkg::osd_video_cfg_t'(spi_dat);
      end
    end
  end

  // --------------------------------------------------
  // chipset config
  // --------------------------------------------------
  // host writes the shadow at any time
  always_ff @(posedge clk) begin
    if (sel.chip_cfg && first_byte) begin
      chip_shadow <= spi_dat[4:0];
    end
  end

  // chipset only switches while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset) begin
      chipset_cfg <= chip_shadow;
    end
  end

  a_chipset_hold: assert property (@(posedge clk) !reset |=> $stable(chipset_cfg))
    else $error("chipset config changed outside reset");

endmodule

/* osd_video/osd_buffer.sv */
// 2048 byte display buffer with row addressed write and raster read port
`timescale 1ns/1ps

`include "osd_cfg.svh"

module osd_buffer (
  input  logic                      clk,
  input  osd_cmd_pkg::osd_sel_t     sel,
  input  osd_cmd_pkg::osd_dat_cnt_t dat_cnt,
  input  osd_cmd_pkg::osd_byte_t    spi_dat,
  input  osd_video_pkg::buf_addr_t  rd_addr,
  output osd_cmd_pkg::osd_byte_t    rd_data
);

  osd_cmd_pkg::osd_byte_t   mem [`OSD_BUF_DEPTH];
  osd_video_pkg::buf_addr_t wr_addr;
  osd_video_pkg::osd_wr_t   wr;
  logic                     row_load;

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  // row byte picks one of 8 rows of 256
  assign row_load = sel.osd_buffer && (dat_cnt == `OSD_LINE_BYTE);

  // bytes after the row byte are pixel data
  assign wr.we   = sel.osd_buffer && (dat_cnt > `OSD_LINE_BYTE);
  assign wr.data = spi_dat;

  // row times 256, then step once per data byte
  always_ff @(posedge clk) begin
    if (row_load) begin
      wr_addr <= {spi_dat[2:0], 8'h00};
    end else if (sel.dat) begin
      wr_addr <= wr_addr + osd_video_pkg::buf_addr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr_addr] <= wr.data;
    end
  end

  // --------------------------------------------------
  // raster read, one clock
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* osd_video/osd_video_timing.sv */
// beam counters, overlay window and registered blank and pixel outputs
`timescale 1ns/1ps

`include "osd_cfg.svh"

module osd_video_timing (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     sol,
  input  logic                     sof,
  input  logic                     osd_enable,
  output osd_video_pkg::buf_addr_t rd_addr,
  input  osd_cmd_pkg::osd_byte_t   rd_data,
  output logic                     osd_blank,
  output logic                     osd_pixel
);

  osd_video_pkg::hbeam_t horbeam;
  osd_video_pkg::vbeam_t verbeam;
  logic                  osd_enabled;
  logic                  hwin;
  logic                  vwin;
  logic                  osd_frame;
  // one stage to line up with the buffer read
  logic                  frame_d;
  logic [2:0]            pix_sel_d;

  // --------------------------------------------------
  // beam counters
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || sol) begin
      horbeam <= '0;
    end else begin
      horbeam <= horbeam + osd_video_pkg::hbeam_t'(1);
    end
  end

  // sof always comes with an sol
  always_ff @(posedge clk) begin
    if (reset || sof) begin
      verbeam <= '0;
    end else if (sol) begin
      verbeam <= verbeam + osd_video_pkg::vbeam_t'(1);
    end
  end

  // enable only changes on a frame boundary
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_enabled <= 1'b0;
    end else if (sof) begin
      osd_enabled <= osd_enable;
    end
  end

  // --------------------------------------------------
  // window and buffer address
  // --------------------------------------------------
  assign hwin = (horbeam >= `OSD_HWIN_START) && (horbeam <= `OSD_HWIN_END);
  assign vwin = (verbeam >= `OSD_VWIN_START) && (verbeam <= `OSD_VWIN_END);
  assign osd_frame = hwin && vwin && osd_enabled;

  // the four 128 clock quarters of the window map to 64 byte blocks
  assign rd_addr = {verbeam[5:3], horbeam[8] ^ horbeam[7], ~horbeam[7], horbeam[6:1]};

  // --------------------------------------------------
  // output stage
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_d   <= 1'b0;
      pix_sel_d <= '0;
    end else begin
      frame_d   <= osd_frame;
      pix_sel_d <= verbeam[2:0];
    end
  end

  // line within the row picks the bit of the byte
  always_ff @(posedge clk) begin
    if (reset) begin
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      osd_blank <= frame_d;
      osd_pixel <= frame_d & rd_data[pix_sel_d];
    end
  end

  a_pixel_in_blank: assert property (@(posedge clk) disable iff (reset)
    osd_pixel |-> osd_blank)
    else $error("osd pixel outside the blank window");

endmodule

/* rtl/osd_top.sv */
// osd controller top, host command decode, registers, buffer and overlay
`timescale 1ns/1ps

module osd_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        spi_rx,
  input  logic                        spi_cmd,
  input  osd_cmd_pkg::osd_byte_t      spi_dat,
  input  logic                        sol,
  input  logic                        sof,
  output logic                        osd_blank,
  output logic                        osd_pixel,
  output logic                        osd_enable,
  output logic                        key_disable,
  output logic                        usrrst,
  output logic                        cpurst,
  output logic                        cpuhlt,
  output osd_cmd_pkg::osd_video_cfg_t video_cfg,
  output osd_cmd_pkg::chipset_cfg_t   chipset_cfg
);

  osd_cmd_pkg::osd_sel_t        sel;
  osd_cmd_pkg::osd_dat_cnt_t    dat_cnt;
  osd_cmd_pkg::osd_reset_ctrl_t reset_ctrl;
  osd_video_pkg::buf_addr_t     rd_addr;
  osd_cmd_pkg::osd_byte_t       rd_data;

  // --------------------------------------------------
  // host side
  // --------------------------------------------------
  osd_cmd_decoder u_osd_cmd_decoder (
    .clk     (clk),
    .reset   (reset),
    .spi_rx  (spi_rx),
    .spi_cmd (spi_cmd),
    .spi_dat (spi_dat),
    .sel     (sel),
    .dat_cnt (dat_cnt)
  );

  osd_config_regs u_osd_config_regs (
    .clk         (clk),
    .reset       (reset),
    .sel         (sel),
    .dat_cnt     (dat_cnt),
    .spi_dat     (spi_dat),
    .reset_ctrl  (reset_ctrl),
    .osd_enable  (osd_enable),
    .key_disable (key_disable),
    .video_cfg   (video_cfg),
    .chipset_cfg (chipset_cfg)
  );

  // split out to the core reset lines
  assign cpuhlt = reset_ctrl.cpuhlt;
  assign cpurst = reset_ctrl.cpurst;
  assign usrrst = reset_ctrl.usrrst;

  // --------------------------------------------------
  // video side
  // --------------------------------------------------
  osd_buffer u_osd_buffer (
    .clk     (clk),
    .sel     (sel),
    .dat_cnt (dat_cnt),
    .spi_dat (spi_dat),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  osd_video_timing u_osd_video_timing (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

/* tests/osd_top_tb.sv */
// osd controller testbench that replays the command trace and checks the raster overlay
`timescale 1ns/1ps

`include "osd_cfg.svh"

module osd_top_tb;

  localparam string TRACE_FILE  = "tests/osd_trace.txt";
  localparam int    LINE_CLKS   = 1816;
  localparam int    FRAME_LINES = 262;
  // 64 window lines of 512 clocks
  localparam int    WIN_CLKS    = 64 * 512;

  logic                         clk;
  logic                         reset;
  logic                         spi_rx;
  logic                         spi_cmd;
  osd_cmd_pkg::osd_byte_t       spi_dat;
  logic                         sol;
  logic                         sof;
  logic                         osd_blank;
  logic                         osd_pixel;
  logic                         osd_enable;
  logic                         key_disable;
  logic                         usrrst;
  logic                         cpurst;
  logic                         cpuhlt;
  osd_cmd_pkg::osd_video_cfg_t  video_cfg;
  osd_cmd_pkg::chipset_cfg_t    chipset_cfg;

  // expected register outputs in the order of out_names
  string      out_names [7] = '{"osd_enable", "key_disable", "usrrst", "cpurst",
                                "cpuhlt", "video_cfg", "chipset_cfg"};
  logic [7:0] exp_tab [7];
  // fill byte of each buffer row
  logic [7:0] row_fill [8];

  // tracked beam and the two clock output lag
  osd_video_pkg::hbeam_t hb;
  osd_video_pkg::vbeam_t vb;
  logic                  fen;
  logic                  blank_d1;
  logic                  blank_d2;
  logic                  pix_d1;
  logic                  pix_d2;

  int     n_checks;
  int     n_errors;
  longint cycles;
  longint cycle_limit;

  osd_top u_osd_top (
    .clk         (clk),
    .reset       (reset),
    .spi_rx      (spi_rx),
    .spi_cmd     (spi_cmd),
    .spi_dat     (spi_dat),
    .sol         (sol),
    .sof         (sof),
    .osd_blank   (osd_blank),
    .osd_pixel   (osd_pixel),
    .osd_enable  (osd_enable),
    .key_disable (key_disable),
    .usrrst      (usrrst),
    .cpurst      (cpurst),
    .cpuhlt      (cpuhlt),
    .video_cfg   (video_cfg),
    .chipset_cfg (chipset_cfg)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // --------------------------------------------------
  // run limit
  // --------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout, trace still running after %0d cycles", cycles);
      $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // worst case per byte is the strobe plus 3 idle cycles
  function automatic longint estimate_cycles();
    int     fd;
    int     a;
    string  line;
    byte    kind;
    longint n = 0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      return 0;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2) begin
        continue;
      end
      kind = line.getc(0);
      if (kind == "C" || kind == "D") begin
        n += 4;
      end else if (kind == "F") begin
        n += 261 * 4;
      end else if (kind == "R") begin
        n += 2;
      end else if (kind == "V") begin
        void'($sscanf(line, "V %h", a));
        n += longint'(a) * FRAME_LINES * LINE_CLKS;
      end
    end
    $fclose(fd);
    return (n + 100) * 11 / 10;
  endfunction

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic logic [7:0] dut_value(input int idx);
    case (idx)
      0:       return {7'd0, osd_enable};
      1:       return {7'd0, key_disable};
      2:       return {7'd0, usrrst};
      3:       return {7'd0, cpurst};
      4:       return {7'd0, cpuhlt};
      5:       return video_cfg;
      default: return {3'd0, chipset_cfg};
    endcase
  endfunction

  // overlay idle outside a raster run
  task automatic compare_outputs();
    for (int i = 0; i < 7; i++) begin
      check_value(out_names[i], dut_value(i), exp_tab[i]);
    end
    check_value("osd_blank", {7'd0, osd_blank}, 8'h00);
    check_value("osd_pixel", {7'd0, osd_pixel}, 8'h00);
  endtask

  task automatic set_expected(input string name, input logic [7:0] value);
    logic found;
    found = 1'b0;
    for (int i = 0; i < 7; i++) begin
      if (out_names[i] == name) begin
        exp_tab[i] = value;
        found = 1'b1;
      end
    end
    if (!found) begin
      n_errors++;
      $display("trace names an output that does not exist: %s", name);
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  // cpu held and everything else clear while chipset keeps its staged value
  task automatic pulse_reset();
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    exp_tab[0] = 8'h00;
    exp_tab[1] = 8'h00;
    exp_tab[2] = 8'h00;
    exp_tab[3] = 8'h01;
    exp_tab[4] = 8'h01;
    exp_tab[5] = 8'h00;
    hb = '0;
    vb = '0;
    fen = 1'b0;
    blank_d1 = 1'b0;
    blank_d2 = 1'b0;
    pix_d1 = 1'b0;
    pix_d2 = 1'b0;
  endtask

  task automatic send_byte(input logic cmd, input logic [7:0] value);
    int unsigned gap;
    spi_rx = 1'b1;
    spi_cmd = cmd;
    spi_dat = value;
    @(posedge clk);
    #2;
    spi_rx = 1'b0;
    spi_cmd = 1'b0;
    gap = $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge clk);
      #2;
    end
  endtask

  // three header bytes and the row byte before one full row
  task automatic fill_row(input logic [2:0] row, input logic [7:0] fill);
    send_byte(1'b1, {osd_cmd_pkg::OSD_BUFFER, 2'b00});
    repeat (3) send_byte(1'b0, 8'h00);
    send_byte(1'b0, {5'd0, row});
    repeat (256) send_byte(1'b0, fill);
    row_fill[row] = fill;
  endtask

  // --------------------------------------------------
  // raster driver and overlay model
  // --------------------------------------------------
  task automatic run_frames(input int n);
    int   blanks;
    logic win;
    for (int f = 0; f < n; f++) begin
      blanks = 0;
      for (int l = 0; l < FRAME_LINES; l++) begin
        for (int h = 0; h < LINE_CLKS; h++) begin
          sol = (h == 0);
          sof = (h == 0) && (l == 0);
          check_value("osd_blank", {7'd0, osd_blank}, {7'd0, blank_d2});
          check_value("osd_pixel", {7'd0, osd_pixel}, {7'd0, pix_d2});
          if (osd_blank) begin
            blanks++;
          end
          @(posedge clk);
          // window of the cycle that just ended
          win = fen && (hb >= `OSD_HWIN_START) && (hb <= `OSD_HWIN_END) &&
                (vb >= `OSD_VWIN_START) && (vb <= `OSD_VWIN_END);
          blank_d2 = blank_d1;
          blank_d1 = win;
          pix_d2 = pix_d1;
          pix_d1 = win && row_fill[vb[5:3]][vb[2:0]];
          hb = sol ? '0 : hb + osd_video_pkg::hbeam_t'(1);
          if (sof) begin
            vb = '0;
            fen = exp_tab[0][0];
          end else if (sol) begin
            vb = vb + osd_video_pkg::vbeam_t'(1);
          end
          #2;
        end
      end
      n_checks++;
      assert (blanks == (fen ? WIN_CLKS : 0)) else begin
        n_errors++;
        $display("Mismatch osd_blank count: got 0x%0h, expected 0x%0h",
                 blanks, fen ? WIN_CLKS : 0);
      end
    end
    sol = 1'b0;
    sof = 1'b0;
  endtask

  // --------------------------------------------------
  // trace replay
  // --------------------------------------------------
  initial begin
    int    fd;
    int    a;
    int    b;
    byte   kind;
    string line;
    string name;
    logic  pending;
    void'($urandom(43));
    clk = 1'b0;
    reset = 1'b1;
    spi_rx = 1'b0;
    spi_cmd = 1'b0;
    spi_dat = '0;
    sol = 1'b0;
    sof = 1'b0;
    n_checks = 0;
    n_errors = 0;
    cycles = 0;
    pending = 1'b0;
    exp_tab[6] = 8'h00;
    for (int i = 0; i < 8; i++) begin
      row_fill[i] = 8'h00;
    end
    cycle_limit = estimate_cycles();
    pulse_reset();
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open the trace file %s", TRACE_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        kind = line.getc(0);
        // a run of E records is checked as a whole
        if (kind != "E" && pending) begin
          compare_outputs();
          pending = 1'b0;
        end
        case (kind)
          "C": begin
            void'($sscanf(line, "C %h", a));
            send_byte(1'b1, a[7:0]);
          end
          "D": begin
            void'($sscanf(line, "D %h", a));
            send_byte(1'b0, a[7:0]);
          end
          "F": begin
            void'($sscanf(line, "F %h %h", a, b));
            fill_row(a[2:0], b[7:0]);
          end
          "E": begin
            void'($sscanf(line, "E %s %h", name, a));
            set_expected(name, a[7:0]);
            pending = 1'b1;
          end
          "R": pulse_reset();
          "V": begin
            void'($sscanf(line, "V %h", a));
            run_frames(a);
          end
          default: begin
            n_errors++;
            $display("trace holds a record of unknown type: %s", line);
          end
        endcase
      end
      if (pending) begin
        compare_outputs();
      end
      $fclose(fd);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* tests/osd_trace.txt */
# C byte: command byte | D byte: data byte | F row fill: buffer row fill | R: reset pulse
# E output value: expected output value | V n: run n raster frames | all values hex
E cpuhlt 1
E cpurst 1
C 08
D 04
E cpurst 0
D 03
D 07
E cpurst 0
C 08
D 01
E cpuhlt 0
E usrrst 1
C 34
D a5
E video_cfg a5
D 3c
E video_cfg a5
C 10
D ff
E video_cfg a5
C 04
D 15
E chipset_cfg 0
F 0 ff
F 1 00
F 2 ff
F 3 00
F 4 ff
F 5 00
F 6 ff
F 7 00
C 28
D 01
E osd_enable 1
V 1
R
E chipset_cfg 15
V 1
C 28
D 03
E osd_enable 1
E key_disable 1
V 1

/* osd_top.f */
+incdir+common
common/osd_cmd_pkg.sv
common/osd_video_pkg.sv
rtl/osd_cmd_decoder.sv
rtl/osd_config_regs.sv
osd_video/osd_buffer.sv
osd_video/osd_video_timing.sv
rtl/osd_top.sv
tests/osd_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the osd controller testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f osd_top.f --top-module osd_top_tb \
    --Mdir obj_dir -o osd_top_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/osd_top_sim); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
